/* dcache_settings.svh */
// cache geometry and bus widths, included by the package and every cache module
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// load/store side
`define DCACHE_ADDR_W      32
`define DCACHE_DATA_W      32

// one line is four words
`define DCACHE_LINE_W      128

// two ways, eight sets
`define DCACHE_WAYS        2
`define DCACHE_SETS        8

// address split, must add up to DCACHE_ADDR_W
`define DCACHE_INDEX_W     3
`define DCACHE_WORD_OFF_W  2
`define DCACHE_BYTE_OFF_W  2
`define DCACHE_TAG_W       25

`endif

/* dcache_pkg.sv */
// shared types of the data cache, referenced by scoped name from each module
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // store width, doubles as the only opcode
    typedef enum logic [1:0] {
        WIDTH_NONE = 2'd0,
        WIDTH_BYTE = 2'd1,
        WIDTH_HALF = 2'd2,
        WIDTH_WORD = 2'd3
    } width_e;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]      tag;
        logic [`DCACHE_INDEX_W-1:0]    index;
        logic [`DCACHE_WORD_OFF_W-1:0] word_off;
        logic [`DCACHE_BYTE_OFF_W-1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        logic                      we;     // 1 = store
        width_e                    width;
        addr_fields_t              addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                      rd_req;   // refill
        logic                      wb_req;   // write-back of a dirty victim
        logic [`DCACHE_ADDR_W-1:0] addr;     // line aligned
        logic [`DCACHE_LINE_W-1:0] line;
    } mem_req_t;

    typedef enum logic [1:0] {
        ST_COMPARE    = 2'd0,
        ST_WRITE_BACK = 2'd1,
        ST_REFILL     = 2'd2,
        ST_RESPOND    = 2'd3
    } state_e;

    // byte lanes written inside one word, odd halfwords write nothing
    function automatic logic [`DCACHE_DATA_W/8-1:0] store_be(
        width_e                        width,
        logic [`DCACHE_BYTE_OFF_W-1:0] byte_off
    );
        logic [`DCACHE_DATA_W/8-1:0] be;
        case (width)
            WIDTH_BYTE: be = 4'b0001 << byte_off;
            WIDTH_HALF: be = byte_off[0] ? 4'b0000 : (4'b0011 << byte_off);
            WIDTH_WORD: be = 4'b1111;    // byte offset ignored
            default:    be = 4'b0000;
        endcase
        return be;
    endfunction

endpackage

`default_nettype wire

/* dcache_ctrl.sv */
// miss FSM of the data cache, sequences compare, write-back, refill and the reply
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                req_valid_i,
    input  wire dcache_pkg::cpu_req_t          cpu_req_i,
    input  wire                                tag_hit_i,
    input  wire                                hit_way_i,
    input  wire                                victim_way_i,
    input  wire                                victim_dirty_i,
    input  wire [`DCACHE_TAG_W-1:0]            victim_tag_i,
    input  wire [`DCACHE_LINE_W-1:0]           victim_line_i,
    input  wire [`DCACHE_DATA_W-1:0]           hit_rdata_i,
    input  wire                                ram_ready_i,
    input  wire [`DCACHE_LINE_W-1:0]           ram_line_i,
    output logic                               tag_upd_o,
    output logic                               data_wr_o,
    output logic                               refill_o,
    output logic                               upd_way_o,
    output dcache_pkg::addr_fields_t           upd_fields_o,
    output dcache_pkg::width_e                 wr_width_o,
    output logic [`DCACHE_DATA_W-1:0]          wr_data_o,
    output dcache_pkg::mem_req_t               mem_req_o,
    output logic                               ready_o,
    output logic                               hit_o,
    output logic [`DCACHE_DATA_W-1:0]          rdata_o
);

    localparam int OFF_W = `DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W;

    dcache_pkg::state_e state_q;

    logic                      writes_bytes;
    logic                      req_we_q;     // latched miss really stores bytes
    logic                      rd_req_q;
    logic                      wb_req_q;
    logic [`DCACHE_ADDR_W-1:0] mem_addr_q;
    logic [`DCACHE_LINE_W-1:0] wb_line_q;

    assign writes_bytes = cpu_req_i.we &&
        (|dcache_pkg::store_be(cpu_req_i.width, cpu_req_i.addr.byte_off));

    assign mem_req_o = '{
        rd_req: rd_req_q,
        wb_req: wb_req_q,
        addr:   mem_addr_q,
        line:   wb_line_q
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= dcache_pkg::ST_COMPARE;
            ready_o   <= 1'b0;
            hit_o     <= 1'b0;
            tag_upd_o <= 1'b0;
            data_wr_o <= 1'b0;
            refill_o  <= 1'b0;
            rd_req_q  <= 1'b0;
            wb_req_q  <= 1'b0;
        end else begin
            // all strobes are single pulses
            ready_o   <= 1'b0;
            tag_upd_o <= 1'b0;
            data_wr_o <= 1'b0;
            refill_o  <= 1'b0;
            rd_req_q  <= 1'b0;
            wb_req_q  <= 1'b0;
            case (state_q)
                dcache_pkg::ST_COMPARE: begin
                    if (req_valid_i) begin
                        if (tag_hit_i) begin
                            ready_o   <= 1'b1;
                            hit_o     <= 1'b1;
                            tag_upd_o <= 1'b1;
                            data_wr_o <= writes_bytes;
                            state_q   <= dcache_pkg::ST_RESPOND;
                        end else if (victim_dirty_i) begin
                            wb_req_q <= 1'b1;
                            state_q  <= dcache_pkg::ST_WRITE_BACK;
                        end else begin
                            rd_req_q <= 1'b1;
                            state_q  <= dcache_pkg::ST_REFILL;
                        end
                    end
                end
                dcache_pkg::ST_WRITE_BACK: begin
                    if (ram_ready_i) begin
                        rd_req_q <= 1'b1;
                        state_q  <= dcache_pkg::ST_REFILL;
                    end
                end
                dcache_pkg::ST_REFILL: begin
                    if (ram_ready_i) begin
                        ready_o   <= 1'b1;
                        hit_o     <= 1'b0;
                        tag_upd_o <= 1'b1;
                        refill_o  <= 1'b1;
                        data_wr_o <= req_we_q;   // write allocate merges the store
                        state_q   <= dcache_pkg::ST_RESPOND;
                    end
                end
                dcache_pkg::ST_RESPOND: begin
                    state_q <= dcache_pkg::ST_COMPARE;   // held request not taken again
                end
                default: begin
                    state_q <= dcache_pkg::ST_COMPARE;
                end
            endcase
        end
    end

    // request latch, memory address and read word
    always_ff @(posedge clk) begin
        case (state_q)
            dcache_pkg::ST_COMPARE: begin
                if (req_valid_i) begin
                    upd_fields_o <= cpu_req_i.addr;
                    wr_width_o   <= cpu_req_i.width;
                    wr_data_o    <= cpu_req_i.wdata;
                    req_we_q     <= writes_bytes;
                    upd_way_o    <= tag_hit_i ? hit_way_i : victim_way_i;
                    rdata_o      <= hit_rdata_i;
                    if (!tag_hit_i && victim_dirty_i) begin
                        mem_addr_q <= {victim_tag_i, cpu_req_i.addr.index, {OFF_W{1'b0}}};
                        wb_line_q  <= victim_line_i;
                    end else if (!tag_hit_i) begin
                        mem_addr_q <= {cpu_req_i.addr.tag, cpu_req_i.addr.index,
                                       {OFF_W{1'b0}}};
                    end
                end
            end
            dcache_pkg::ST_WRITE_BACK: begin
                if (ram_ready_i) begin
                    mem_addr_q <= {upd_fields_o.tag, upd_fields_o.index, {OFF_W{1'b0}}};
                end
            end
            dcache_pkg::ST_REFILL: begin
                if (ram_ready_i) begin
                    rdata_o <= ram_line_i[upd_fields_o.word_off*`DCACHE_DATA_W +: `DCACHE_DATA_W];
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* dcache_tag_store.sv */
// tag, valid, dirty and LRU state of the cache with hit detection and victim choice
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_store (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire dcache_pkg::addr_fields_t      fields_i,
    input  wire dcache_pkg::addr_fields_t      upd_fields_i,
    input  wire                                tag_upd_i,
    input  wire                                refill_i,
    input  wire                                dirty_i,
    input  wire                                upd_way_i,
    output logic                               tag_hit_o,
    output logic                               hit_way_o,
    output logic                               victim_way_o,
    output logic                               victim_dirty_o,
    output logic [`DCACHE_TAG_W-1:0]           victim_tag_o
);

    logic [`DCACHE_TAG_W-1:0]   tag_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]    valid_q [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0]    dirty_q [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0]    lru_q;   // per set, the way used least recently
    logic [`DCACHE_WAYS-1:0]    way_hit;
    logic [`DCACHE_INDEX_W-1:0] idx;
    logic [`DCACHE_INDEX_W-1:0] upd_idx;

    assign idx     = fields_i.index;
    assign upd_idx = upd_fields_i.index;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == fields_i.tag);
        end
    end

    assign tag_hit_o = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid way first, way 0 before way 1, else LRU
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[idx];
        end
    end

    assign victim_dirty_o = valid_q[victim_way_o][idx] && dirty_q[victim_way_o][idx];
    assign victim_tag_o   = tag_q[victim_way_o][idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (tag_upd_i) begin
            lru_q[upd_idx] <= ~upd_way_i;   // other way becomes LRU
            if (refill_i) begin
                valid_q[upd_way_i][upd_idx] <= 1'b1;
                dirty_q[upd_way_i][upd_idx] <= dirty_i;
            end else if (dirty_i) begin
                dirty_q[upd_way_i][upd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_upd_i && refill_i) begin
            tag_q[upd_way_i][upd_idx] <= upd_fields_i.tag;
        end
    end

endmodule

`default_nettype wire

/* dcache_data_store.sv */
// line storage of the cache, merges stores by byte lane and reads words and victim lines
`default_nettype none

`include "dcache_settings.svh"

module dcache_data_store (
    input  wire                                clk,
    input  wire dcache_pkg::addr_fields_t      fields_i,
    input  wire dcache_pkg::addr_fields_t      upd_fields_i,
    input  wire                                wr_i,
    input  wire                                refill_i,
    input  wire                                upd_way_i,
    input  wire dcache_pkg::width_e            wr_width_i,
    input  wire [`DCACHE_DATA_W-1:0]           wr_data_i,
    input  wire [`DCACHE_LINE_W-1:0]           refill_line_i,
    input  wire                                hit_way_i,
    output logic [`DCACHE_DATA_W-1:0]          rdata_o,
    input  wire                                victim_way_i,
    output logic [`DCACHE_LINE_W-1:0]          victim_line_o
);

    localparam int LANES = `DCACHE_DATA_W / 8;
    localparam int WORDS = `DCACHE_LINE_W / `DCACHE_DATA_W;

    logic [`DCACHE_LINE_W-1:0] line_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_LINE_W-1:0] refill_buf;   // ram line is only valid with ram_ready
    logic [`DCACHE_LINE_W-1:0] base_line;
    logic [`DCACHE_LINE_W-1:0] line_mask;
    logic [`DCACHE_LINE_W-1:0] new_line;
    logic [LANES-1:0]          be;
    logic [`DCACHE_DATA_W-1:0] lane_data;

    assign be = dcache_pkg::store_be(wr_width_i, upd_fields_i.byte_off);

    // byte and half data sit in the low bits of the store word
    assign lane_data = (wr_width_i == dcache_pkg::WIDTH_WORD) ? wr_data_i
                     : wr_data_i << {upd_fields_i.byte_off, 3'b000};

    always_comb begin
        line_mask = '0;
        for (int b = 0; b < LANES; b++) begin
            line_mask[upd_fields_i.word_off*`DCACHE_DATA_W + b*8 +: 8] = {8{be[b]}};
        end
    end

    // merge on top of the stored line for a hit, the incoming line for a refill
    assign base_line = refill_i ? refill_buf : line_q[upd_way_i][upd_fields_i.index];
    assign new_line  = wr_i ? ((base_line & ~line_mask) | ({WORDS{lane_data}} & line_mask))
                     : base_line;

    always_ff @(posedge clk) begin
        refill_buf <= refill_line_i;
        if (refill_i || wr_i) begin
            line_q[upd_way_i][upd_fields_i.index] <= new_line;
        end
    end

    assign rdata_o =
        line_q[hit_way_i][fields_i.index][fields_i.word_off*`DCACHE_DATA_W +: `DCACHE_DATA_W];
    assign victim_line_o = line_q[victim_way_i][fields_i.index];   // write-back data

endmodule

`default_nettype wire

/* dcache_top.sv */
// top level of the two-way data cache between the load/store port and line memory
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                req_valid_i,
    input  wire dcache_pkg::cpu_req_t          cpu_req_i,
    output logic                               ready_o,
    output logic                               hit_o,
    output logic [`DCACHE_DATA_W-1:0]          rdata_o,
    output dcache_pkg::mem_req_t               mem_req_o,
    input  wire                                ram_ready_i,
    input  wire [`DCACHE_LINE_W-1:0]           ram_line_i
);

    logic                      tag_hit;
    logic                      hit_way;
    logic                      victim_way;
    logic                      victim_dirty;
    logic [`DCACHE_TAG_W-1:0]  victim_tag;
    logic [`DCACHE_LINE_W-1:0] victim_line;
    logic [`DCACHE_DATA_W-1:0] hit_rdata;
    logic                      tag_upd;
    logic                      data_wr;    // also marks the line dirty
    logic                      refill;
    logic                      upd_way;
    dcache_pkg::addr_fields_t  upd_fields;
    dcache_pkg::width_e        wr_width;
    logic [`DCACHE_DATA_W-1:0] wr_data;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .cpu_req_i      (cpu_req_i),
        .tag_hit_i      (tag_hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .hit_rdata_i    (hit_rdata),
        .ram_ready_i    (ram_ready_i),
        .ram_line_i     (ram_line_i),
        .tag_upd_o      (tag_upd),
        .data_wr_o      (data_wr),
        .refill_o       (refill),
        .upd_way_o      (upd_way),
        .upd_fields_o   (upd_fields),
        .wr_width_o     (wr_width),
        .wr_data_o      (wr_data),
        .mem_req_o      (mem_req_o),
        .ready_o        (ready_o),
        .hit_o          (hit_o),
        .rdata_o        (rdata_o)
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .fields_i       (cpu_req_i.addr),
        .upd_fields_i   (upd_fields),
        .tag_upd_i      (tag_upd),
        .refill_i       (refill),
        .dirty_i        (data_wr),
        .upd_way_i      (upd_way),
        .tag_hit_o      (tag_hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_store u_data_store (
        .clk            (clk),
        .fields_i       (cpu_req_i.addr),
        .upd_fields_i   (upd_fields),
        .wr_i           (data_wr),
        .refill_i       (refill),
        .upd_way_i      (upd_way),
        .wr_width_i     (wr_width),
        .wr_data_i      (wr_data),
        .refill_line_i  (ram_line_i),
        .hit_way_i      (hit_way),
        .rdata_o        (hit_rdata),
        .victim_way_i   (victim_way),
        .victim_line_o  (victim_line)
    );

endmodule

`default_nettype wire

/* dcache_assertions.sv */
// protocol assertions on the cache ports, bound to the top level by the testbench
`default_nettype none

module dcache_assertions (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       ready_i,
    input wire dcache_pkg::mem_req_t mem_req_i,
    input wire                       ram_ready_i
);

    logic mem_req;
    logic pending_q;   // request out, ram_ready not seen yet

    assign mem_req = mem_req_i.rd_req || mem_req_i.wb_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (mem_req) begin
            pending_q <= 1'b1;
        end else if (ram_ready_i) begin
            pending_q <= 1'b0;
        end
    end

    ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) ready_i |=> !ready_i)
        else $error("ready_o high for more than one cycle");

    req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req_i.rd_req && mem_req_i.wb_req))
        else $error("refill and write-back requested together");

    rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i.rd_req |=> !mem_req_i.rd_req)
        else $error("refill request longer than one cycle");

    wb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i.wb_req |=> !mem_req_i.wb_req)
        else $error("write-back request longer than one cycle");

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n) pending_q |-> !mem_req)
        else $error("new memory request before ram_ready");

endmodule

`default_nettype wire

/* dcache_tb.sv */
// self-checking testbench of the data cache, drives loads and stores against memory and shadow models
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

    localparam int CYCLE_LIMIT = 4000;   // about 80 accesses at 13 cycles worst case, with margin

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      req_valid;
    dcache_pkg::cpu_req_t      cpu_req;
    logic                      ready;
    logic                      hit;
    logic [`DCACHE_DATA_W-1:0] rdata;
    dcache_pkg::mem_req_t      mem_req;
    logic                      ram_ready;
    logic [`DCACHE_LINE_W-1:0] ram_line;

    logic [`DCACHE_LINE_W-1:0] mem_lines [128];   // backing memory, by address bits 10:4
    logic [`DCACHE_LINE_W-1:0] shadow [128];      // what every load should return
    logic [`DCACHE_TAG_W-1:0]  m_tag [2][8];
    logic                      m_valid [2][8];
    logic                      m_dirty [2][8];
    logic                      m_lru [8];
    logic                      exp_wb;
    logic [31:0]               exp_wb_addr;
    logic [31:0]               exp_rd_addr;
    int                        rd_seen = 0;
    int                        wb_seen = 0;
    int                        checks = 0;
    int                        errors = 0;
    int                        test_errors = 0;
    int                        cycles = 0;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    dcache_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .cpu_req_i   (cpu_req),
        .ready_o     (ready),
        .hit_o       (hit),
        .rdata_o     (rdata),
        .mem_req_o   (mem_req),
        .ram_ready_i (ram_ready),
        .ram_line_i  (ram_line)
    );

    bind dcache_top dcache_assertions u_assertions (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready_i     (ready_o),
        .mem_req_i   (mem_req_o),
        .ram_ready_i (ram_ready_i)
    );

    function automatic void check_value(input string name, input logic [127:0] got,
                                        input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word,
                                              input int off);
        return {25'(tag), 3'(idx), 2'(word), 2'(off)};
    endfunction

    // merge a store into the shadow line, odd halfwords and width none write nothing
    function automatic void shadow_store(input logic [31:0] addr, input dcache_pkg::width_e width,
                                         input logic [31:0] data, output logic wrote);
        int la;
        int pos;
        la    = int'(addr[10:4]);
        pos   = int'(addr[3:0]) * 8;   // bit of the addressed byte in the line
        wrote = 1'b1;
        case (width)
            dcache_pkg::WIDTH_BYTE: shadow[la][pos +: 8] = data[7:0];
            dcache_pkg::WIDTH_HALF: begin
                if (addr[0]) begin
                    wrote = 1'b0;
                end else begin
                    shadow[la][pos +: 16] = data[15:0];
                end
            end
            dcache_pkg::WIDTH_WORD: shadow[la][int'(addr[3:2]) * 32 +: 32] = data;
            default: wrote = 1'b0;
        endcase
    endfunction

    function automatic void finish_test(input int num, input string name);
        $display("test %0d, %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endfunction

    // one load or store, the LRU model sets what the memory side must see
    task automatic access(input logic we, input dcache_pkg::width_e width,
                          input logic [31:0] addr, input logic [31:0] wdata);
        logic [2:0]  idx;
        logic [24:0] tag;
        logic        way;
        logic        exp_hit;
        logic        wrote;
        logic [31:0] exp_rdata;
        idx     = addr[6:4];
        tag     = addr[31:7];
        exp_hit = 1'b0;
        way     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        exp_wb = 1'b0;
        if (!exp_hit) begin
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : m_lru[idx]);
            exp_wb            = m_valid[way][idx] && m_dirty[way][idx];
            exp_wb_addr       = {m_tag[way][idx], idx, 4'h0};
            exp_rd_addr       = {addr[31:4], 4'h0};
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        wrote = 1'b0;
        if (we) begin
            shadow_store(addr, width, wdata, wrote);
        end
        if (wrote) begin
            m_dirty[way][idx] = 1'b1;
        end
        m_lru[idx] = ~way;
        exp_rdata  = shadow[addr[10:4]][int'(addr[3:2]) * 32 +: 32];
        rd_seen    = 0;
        wb_seen    = 0;
        req_valid  = 1'b1;
        cpu_req    = '{we: we, width: width, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        check_value("hit_o", hit, exp_hit);
        if (!we) begin
            check_value("rdata_o", rdata, exp_rdata);
        end
        check_value("mem_req_o.rd_req count", rd_seen, exp_hit ? 0 : 1);
        check_value("mem_req_o.wb_req count", wb_seen, exp_wb);
        req_valid = 1'b0;
    endtask

    // memory model, answers each request pulse after 1 to 4 cycles
    initial begin
        logic [6:0] la;
        ram_ready = 1'b0;
        ram_line  = '0;
        forever begin
            if (mem_req.rd_req === 1'b1 || mem_req.wb_req === 1'b1) begin
                la = mem_req.addr[10:4];
                if (mem_req.wb_req) begin
                    wb_seen++;
                    check_value("mem_req_o.addr", mem_req.addr, exp_wb_addr);
                    check_value("mem_req_o.line", mem_req.line, shadow[la]);
                    mem_lines[la] = mem_req.line;
                end else begin
                    rd_seen++;
                    check_value("mem_req_o.addr", mem_req.addr, exp_rd_addr);
                end
                repeat ($urandom_range(4, 1)) @(negedge clk);
                ram_ready = 1'b1;
                ram_line  = mem_lines[la];
                @(negedge clk);
                ram_ready = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    initial begin
        logic [31:0]        a;
        dcache_pkg::width_e w;
        logic               we;
        void'($urandom(32'hda6c_423e));
        for (int i = 0; i < 128; i++) begin
            mem_lines[i] = {$urandom, $urandom, $urandom, $urandom};
            shadow[i]    = mem_lines[i];
        end
        for (int s = 0; s < 8; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        rst_n     = 1'b0;
        req_valid = 1'b0;
        cpu_req   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("ready_o", ready, 0);
        check_value("hit_o", hit, 0);
        check_value("mem_req_o.rd_req", mem_req.rd_req, 0);
        check_value("mem_req_o.wb_req", mem_req.wb_req, 0);
        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(1, 0, 2, 0), 32'h0);
        finish_test(1, "reset and first read miss");

        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(1, 0, 1, 0), 32'h0);
        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(1, 0, 2, 0), 32'h0);
        finish_test(2, "read hit");

        for (int off = 0; off < 4; off++) begin
            access(1'b1, dcache_pkg::WIDTH_BYTE, make_addr(1, 0, 3, off), $urandom);
            access(1'b1, dcache_pkg::WIDTH_HALF, make_addr(1, 0, 1, off), $urandom);
        end
        access(1'b1, dcache_pkg::WIDTH_WORD, make_addr(1, 0, 0, 0), $urandom);
        access(1'b1, dcache_pkg::WIDTH_NONE, make_addr(1, 0, 2, 0), $urandom);
        // store misses allocate their line
        access(1'b1, dcache_pkg::WIDTH_BYTE, make_addr(2, 1, 0, 3), $urandom);
        access(1'b1, dcache_pkg::WIDTH_HALF, make_addr(3, 2, 2, 2), $urandom);
        access(1'b1, dcache_pkg::WIDTH_WORD, make_addr(4, 3, 1, 0), $urandom);
        access(1'b1, dcache_pkg::WIDTH_HALF, make_addr(5, 4, 0, 1), $urandom);
        for (int t = 0; t < 5; t++) begin
            for (int wd = 0; wd < 4; wd++) begin
                access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(t + 1, t, wd, 0), 32'h0);
            end
        end
        finish_test(3, "store widths and offsets");

        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(1, 5, 0, 0), 32'h0);
        access(1'b1, dcache_pkg::WIDTH_WORD, make_addr(2, 5, 1, 0), $urandom);
        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(1, 5, 0, 0), 32'h0);   // way 1 now LRU
        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(3, 5, 2, 0), 32'h0);   // dirty victim
        access(1'b0, dcache_pkg::WIDTH_WORD, make_addr(2, 5, 1, 0), 32'h0);   // clean victim
        finish_test(4, "LRU eviction");

        for (int i = 0; i < 40; i++) begin
            we = 1'($urandom_range(1, 0));
            w  = dcache_pkg::width_e'($urandom_range(3, 0));
            a  = make_addr(8 + $urandom_range(3, 0), $urandom_range(3, 0),
                           $urandom_range(3, 0), $urandom_range(3, 0));
            if (w == dcache_pkg::WIDTH_WORD) begin
                a[1:0] = 2'b00;
            end
            access(we, w, a, $urandom);
        end
        finish_test(5, "random mix");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
+incdir+.
dcache_pkg.sv
dcache_ctrl.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_top.sv
dcache_assertions.sv
dcache_tb.sv

/* Makefile */
# Verilator build and run of the data cache testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := dcache_tb
FILELIST  := dcache.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
